//--- sim.f
rtl/autotest_uut_pkg.sv
rtl/autotest_sd_pkg.sv
rtl/sd_block_reader.sv
rtl/field_loader.sv
rtl/result_checker.sv
rtl/test_sequencer.sv
rtl/autotest_top.sv
bench/autotest_assert.sv
bench/tb_autotest.sv

//--- Makefile
# Verilator build and run for the SD self-test harness

VERILATOR ?= verilator
TOP       ?= tb_autotest
RTL_TOP   ?= autotest_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) \
		rtl/autotest_uut_pkg.sv rtl/autotest_sd_pkg.sv rtl/sd_block_reader.sv \
		rtl/field_loader.sv rtl/result_checker.sv rtl/test_sequencer.sv \
		rtl/autotest_top.sv

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_autotest.sv
// Testbench for the SD self-test harness.
// Models the SPI host with its card and an adder UUT, then runs
// directed tests on reset state, good, mixed and bad records.

`timescale 1ns/100ps

module tb_autotest;

  import autotest_sd_pkg::*;
  import autotest_uut_pkg::*;

  localparam int N_BLOCKS   = 16;
  localparam int MAX_BUSY   = 4;
  localparam int REC_CYCLES = BLOCK_BYTES * (MAX_BUSY + 3) + 100;
  localparam int N_READS    = 12;
  localparam int WD_CYCLES  = 2 * (N_READS * REC_CYCLES + 3000);

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        spi_busy_i = 1'b0;
  sd_byte_t    spi_data_out_i = '0;
  logic        uut_end_i = 1'b0;
  result_t     uut_result_i = '0;
  block_addr_t spi_block_addr_o;
  logic        spi_r_block_o;
  logic        spi_r_byte_o;
  logic        spi_rst_o;
  logic        uut_rst_o;
  logic        halted_o;
  in_a_t       uut_in_a_o;
  in_b_t       uut_in_b_o;
  err_count_t  error_count_o;

  integer   seed = 32'hea3d40da;
  sd_byte_t card_mem [0:N_BLOCKS*BLOCK_BYTES-1];

  autotest_top i_autotest_top (.*);

  always #5 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_count(input string name, input err_count_t got, input err_count_t exp);
    if (got !== exp)
      report_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input block_addr_t got, input block_addr_t exp);
    if (got !== exp)
      report_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_result(input string name, input result_t got, input result_t exp);
    if (got !== exp)
      report_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  function automatic int busy_len();
    return 1 + ($unsigned($random(seed)) % MAX_BUSY);
  endfunction

  // block bytes off the end of the card still depend on the address
  function automatic sd_byte_t card_byte(input block_addr_t blk, input int idx);
    int off;
    off = int'(blk - START_BLOCK);
    if (off >= 0 && off < N_BLOCKS)
      return card_mem[off*BLOCK_BYTES + idx];
    return sd_byte_t'((blk ^ (blk >> 8) ^ (blk >> 16) ^ (blk >> 24)) * 8'h3b) ^
           sd_byte_t'(idx) ^ sd_byte_t'((idx >> 8) * 8'h65);
  endfunction

  function automatic logic [31:0] card_word(input block_addr_t blk, input int offs);
    return {card_byte(blk, offs + 3), card_byte(blk, offs + 2),
            card_byte(blk, offs + 1), card_byte(blk, offs)};
  endfunction

  task automatic fill_card();
    for (int i = 0; i < N_BLOCKS*BLOCK_BYTES; i++)
      card_mem[i] = sd_byte_t'(i * 7) ^ sd_byte_t'(i >> 8) ^ 8'h5a;
  endtask

  task automatic write_record(input int rec, input sig_t sig, input in_a_t a, input in_b_t b,
                              input result_t exp);
    int base;
    base = rec * BLOCK_BYTES;
    for (int k = 0; k < 4; k++) begin
      card_mem[base + SIG_OFFSET + k] = sig[(3-k)*8 +: 8];
      card_mem[base + A_OFFSET + k]   = a[k*8 +: 8];
      card_mem[base + B_OFFSET + k]   = b[k*8 +: 8];
      card_mem[base + EXP_OFFSET + k] = exp[k*8 +: 8];
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic serve_busy();
    spi_busy_i <= 1'b1;
    repeat (busy_len()) @(posedge clk);
    spi_busy_i <= 1'b0;
  endtask

  // SPI host and card
  initial begin : spi_host
    logic in_block;
    int   byte_cnt;
    in_block = 1'b0;
    byte_cnt = 0;
    forever begin
      @(posedge clk);
      if (spi_rst_o) begin
        serve_busy();
      end else if (spi_r_byte_o) begin
        spi_busy_i <= 1'b1;
        repeat (busy_len()) @(posedge clk);
        spi_busy_i     <= 1'b0;
        spi_data_out_i <= card_byte(spi_block_addr_o, byte_cnt % BLOCK_BYTES);
        byte_cnt++;
      end else if (spi_r_block_o && !in_block) begin
        in_block = 1'b1;
        byte_cnt = 0;
        serve_busy();
      end else if (!spi_r_block_o) begin
        in_block = 1'b0;
      end
    end
  end

  // adder UUT that checks its operands while it runs
  initial begin : uut_model
    logic [31:0] a_exp;
    logic [31:0] b_exp;
    forever begin
      @(posedge clk);
      if (!uut_rst_o) begin
        a_exp = card_word(spi_block_addr_o, A_OFFSET);
        b_exp = card_word(spi_block_addr_o, B_OFFSET);
        repeat (busy_len()) begin
          check_result("uut_in_a_o", result_t'(uut_in_a_o), a_exp);
          check_result("uut_in_b_o", result_t'(uut_in_b_o), b_exp);
          @(posedge clk);
        end
        uut_result_i <= uut_in_a_o + uut_in_b_o;
        uut_end_i    <= 1'b1;
        @(posedge clk);
        uut_end_i <= 1'b0;
      end
    end
  end

  task automatic wait_addr(input block_addr_t target);
    while (spi_block_addr_o !== target) begin
      if (halted_o)
        report_failure("harness halted before reaching the expected block");
      @(posedge clk);
    end
  endtask

  task automatic wait_halt();
    while (!halted_o)
      @(posedge clk);
  endtask

  task automatic expect_reset_state();
    fill_card();
    apply_reset();
    check_flag("spi_r_block_o", spi_r_block_o, 1'b0);
    check_flag("spi_r_byte_o", spi_r_byte_o, 1'b0);
    check_flag("spi_rst_o", spi_rst_o, 1'b0);
    check_flag("uut_rst_o", uut_rst_o, 1'b1);
    check_flag("halted_o", halted_o, 1'b0);
    check_count("error_count_o", error_count_o, '0);
    check_addr("spi_block_addr_o", spi_block_addr_o, START_BLOCK);
  endtask

  task automatic run_good_records();
    in_a_t a;
    in_b_t b;
    fill_card();
    for (int r = 0; r < 3; r++) begin
      a = $random(seed);
      b = $random(seed);
      write_record(r, SIGNATURE, a, b, a + b);
    end
    write_record(3, 32'h0, '0, '0, '0);
    apply_reset();
    for (int r = 1; r <= 3; r++) begin
      wait_addr(START_BLOCK + r);
      check_count("error_count_o", error_count_o, '0);
    end
    wait_halt();
    check_addr("spi_block_addr_o", spi_block_addr_o, START_BLOCK + 3);
  endtask

  task automatic count_mixed_errors();
    in_a_t      a;
    in_b_t      b;
    err_count_t wrong;
    err_count_t exp_count [0:5];
    fill_card();
    wrong = '0;
    for (int r = 0; r < 6; r++) begin
      a = $random(seed);
      b = $random(seed);
      if ($random(seed) & 1) begin
        write_record(r, SIGNATURE, a, b, a + b + 1 + ($unsigned($random(seed)) % 100));
        wrong++;
      end else begin
        write_record(r, SIGNATURE, a, b, a + b);
      end
      exp_count[r] = wrong;
    end
    write_record(6, 32'hAABB_CCDC, '0, '0, '0);
    apply_reset();
    for (int r = 0; r < 6; r++) begin
      wait_addr(START_BLOCK + r + 1);
      check_count("error_count_o", error_count_o, exp_count[r]);
    end
    wait_halt();
    check_count("error_count_o", error_count_o, wrong);
    check_addr("spi_block_addr_o", spi_block_addr_o, START_BLOCK + 6);
  endtask

  task automatic halt_on_bad_signature();
    fill_card();
    write_record(0, 32'hDDCC_BBAA, 32'd1, 32'd2, 32'd3);
    apply_reset();
    wait_halt();
    check_addr("spi_block_addr_o", spi_block_addr_o, START_BLOCK);
    repeat (200) begin
      @(posedge clk);
      check_flag("halted_o", halted_o, 1'b1);
      check_flag("spi_r_block_o", spi_r_block_o, 1'b0);
      check_addr("spi_block_addr_o", spi_block_addr_o, START_BLOCK);
    end
    check_count("error_count_o", error_count_o, '0);
  endtask

  initial begin : watchdog
    repeat (WD_CYCLES) @(posedge clk);
    $display("watchdog expired, harness stuck");
    $display("TEST FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    expect_reset_state();
    run_good_records();
    count_mixed_errors();
    halt_on_bad_signature();
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- bench/autotest_assert.sv
// Handshake checks on the SD block reader.
// Bound into every sd_block_reader instance.

`timescale 1ns/100ps

module autotest_assert (
  input logic clk,
  input logic rst,
  input logic read_req_i,
  input logic read_ack_o,
  input logic spi_busy_i,
  input logic spi_r_byte_o,
  input logic byte_valid_o
);

  // byte request waits for the host to go busy
  byte_req_hold: assert property (@(posedge clk) disable iff (rst)
    spi_r_byte_o && !spi_busy_i |=> spi_r_byte_o)
    else $error("byte request dropped before busy");

  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(read_ack_o) |-> read_req_i)
    else $error("read ack raised without request");

  valid_on_busy_fall: assert property (@(posedge clk) disable iff (rst)
    byte_valid_o |-> $fell(spi_busy_i))
    else $error("byte strobe without busy fall");

endmodule

bind sd_block_reader autotest_assert i_autotest_assert (
  .clk          (clk),
  .rst          (rst),
  .read_req_i   (read_req_i),
  .read_ack_o   (read_ack_o),
  .spi_busy_i   (spi_busy_i),
  .spi_r_byte_o (spi_r_byte_o),
  .byte_valid_o (byte_valid_o)
);

//--- rtl/autotest_top.sv
// SD card driven self-test harness, top level.
// Reads test records from the card through the SPI host, loads the
// operands into the UUT, checks its result and counts the errors.

`timescale 1ns/100ps

module autotest_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         spi_busy_i,
  input  autotest_sd_pkg::sd_byte_t    spi_data_out_i,
  output autotest_sd_pkg::block_addr_t spi_block_addr_o,
  output logic                         spi_r_block_o,
  output logic                         spi_r_byte_o,
  output logic                         spi_rst_o,
  output logic                         uut_rst_o,
  input  logic                         uut_end_i,
  output autotest_uut_pkg::in_a_t      uut_in_a_o,
  output autotest_uut_pkg::in_b_t      uut_in_b_o,
  input  autotest_uut_pkg::result_t    uut_result_i,
  output autotest_sd_pkg::err_count_t  error_count_o,
  output logic                         halted_o
);

  import autotest_sd_pkg::*;
  import autotest_uut_pkg::*;

  logic      read_req;
  logic      read_ack;
  logic      byte_valid;
  byte_idx_t byte_idx;
  sd_byte_t  byte_data;
  sig_t      signature;
  result_t   expected;
  logic      check;

  sd_block_reader i_reader (
    .clk            (clk),
    .rst            (rst),
    .read_req_i     (read_req),
    .read_ack_o     (read_ack),
    .spi_busy_i     (spi_busy_i),
    .spi_data_out_i (spi_data_out_i),
    .spi_r_block_o  (spi_r_block_o),
    .spi_r_byte_o   (spi_r_byte_o),
    .byte_valid_o   (byte_valid),
    .byte_idx_o     (byte_idx),
    .byte_data_o    (byte_data)
  );

  // signature comes off the card most significant byte first
  field_loader #(.field_t(sig_t), .FIELD_OFFSET(SIG_OFFSET), .MSB_FIRST(1'b1)) i_sig_loader (
    .clk(clk), .rst(rst), .byte_valid_i(byte_valid), .byte_idx_i(byte_idx),
    .byte_data_i(byte_data), .field_o(signature)
  );

  field_loader #(.field_t(in_a_t), .FIELD_OFFSET(A_OFFSET), .MSB_FIRST(1'b0)) i_a_loader (
    .clk(clk), .rst(rst), .byte_valid_i(byte_valid), .byte_idx_i(byte_idx),
    .byte_data_i(byte_data), .field_o(uut_in_a_o)
  );

  field_loader #(.field_t(in_b_t), .FIELD_OFFSET(B_OFFSET), .MSB_FIRST(1'b0)) i_b_loader (
    .clk(clk), .rst(rst), .byte_valid_i(byte_valid), .byte_idx_i(byte_idx),
    .byte_data_i(byte_data), .field_o(uut_in_b_o)
  );

  field_loader #(.field_t(result_t), .FIELD_OFFSET(EXP_OFFSET), .MSB_FIRST(1'b0)) i_exp_loader (
    .clk(clk), .rst(rst), .byte_valid_i(byte_valid), .byte_idx_i(byte_idx),
    .byte_data_i(byte_data), .field_o(expected)
  );

  result_checker i_checker (
    .clk           (clk),
    .rst           (rst),
    .check_i       (check),
    .expected_i    (expected),
    .uut_result_i  (uut_result_i),
    .error_count_o (error_count_o)
  );

  test_sequencer i_sequencer (
    .clk          (clk),
    .rst          (rst),
    .spi_busy_i   (spi_busy_i),
    .spi_rst_o    (spi_rst_o),
    .read_req_o   (read_req),
    .read_ack_i   (read_ack),
    .signature_i  (signature),
    .uut_rst_o    (uut_rst_o),
    .uut_end_i    (uut_end_i),
    .check_o      (check),
    .block_addr_o (spi_block_addr_o),
    .halted_o     (halted_o)
  );

endmodule

//--- rtl/test_sequencer.sv
// Test sequencer.
// Resets the SPI host, then per record: read the block, check the
// signature, run the UUT until its end flag, have the result checked
// and step to the next block. A bad signature halts the harness.

`timescale 1ns/100ps

module test_sequencer (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         spi_busy_i,
  output logic                         spi_rst_o,
  output logic                         read_req_o,
  input  logic                         read_ack_i,
  input  autotest_sd_pkg::sig_t        signature_i,
  output logic                         uut_rst_o,
  input  logic                         uut_end_i,
  output logic                         check_o,
  output autotest_sd_pkg::block_addr_t block_addr_o,
  output logic                         halted_o
);

  import autotest_sd_pkg::*;

  typedef enum logic [2:0] {
    S_SPI_RST,
    S_IDLE,
    S_READ,
    S_SIG,
    S_RUN,
    S_CHECK,
    S_ADVANCE,
    S_HALT
  } state_t;

  state_t      state_q;
  state_t      state_d;
  logic        spi_rst_q;
  block_addr_t addr_q;

  assign spi_rst_o    = spi_rst_q;
  assign read_req_o   = (state_q == S_READ);
  assign uut_rst_o    = (state_q != S_RUN);
  assign check_o      = (state_q == S_RUN) && uut_end_i;
  assign block_addr_o = addr_q;
  assign halted_o     = (state_q == S_HALT);

  always_comb begin
    state_d = state_q;
    case (state_q)
      // host acknowledges its reset by going busy
      S_SPI_RST:
        if (spi_busy_i)
          state_d = S_IDLE;
      S_IDLE:
        if (!spi_busy_i)
          state_d = S_READ;
      S_READ:
        if (read_ack_i)
          state_d = S_SIG;
      // let the reader finish the handshake first
      S_SIG:
        if (!read_ack_i) begin
          if (signature_i == SIGNATURE)
            state_d = S_RUN;
          else
            state_d = S_HALT;
        end
      S_RUN:
        if (uut_end_i)
          state_d = S_CHECK;
      S_CHECK:
        state_d = S_ADVANCE;
      S_ADVANCE:
        state_d = S_IDLE;
      S_HALT:
        state_d = S_HALT;
      default:
        state_d = S_HALT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= S_SPI_RST;
      spi_rst_q <= 1'b0;
      addr_q    <= START_BLOCK;
    end else begin
      state_q <= state_d;
      // host reset starts the cycle after release
      spi_rst_q <= (state_d == S_SPI_RST);
      // step while the checker count settles
      if (state_q == S_CHECK)
        addr_q <= addr_q + 1'b1;
    end
  end

endmodule

//--- rtl/result_checker.sv
// Result checker.
// Compares the UUT result with the expected value of the record at
// the end of each run and counts the mismatches.

`timescale 1ns/100ps

module result_checker (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         check_i,
  input  autotest_uut_pkg::result_t    expected_i,
  input  autotest_uut_pkg::result_t    uut_result_i,
  output autotest_sd_pkg::err_count_t  error_count_o
);

  import autotest_sd_pkg::*;
  import autotest_uut_pkg::*;

  logic       mismatch;
  err_count_t err_count_q;

  // uut result is sampled in the end-flag cycle
  assign mismatch = (uut_result_i != expected_i);

  // count spans the whole card
  always_ff @(posedge clk) begin
    if (rst)
      err_count_q <= '0;
    else if (check_i && mismatch)
      err_count_q <= err_count_q + 1'b1;
  end

  assign error_count_o = err_count_q;

endmodule

//--- rtl/field_loader.sv
// Record field loader.
// Picks the bytes of one field out of the block byte stream and
// places each in its lane, lowest lane first or highest lane first.

`timescale 1ns/100ps

module field_loader #(
  parameter type field_t      = logic [31:0],
  parameter int  FIELD_OFFSET = 0,
  parameter bit  MSB_FIRST    = 1'b0
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       byte_valid_i,
  input  autotest_sd_pkg::byte_idx_t byte_idx_i,
  input  autotest_sd_pkg::sd_byte_t  byte_data_i,
  output field_t                     field_o
);

  import autotest_sd_pkg::*;

  localparam int        NBYTES = $bits(field_t) / 8;
  localparam byte_idx_t LO_IDX = byte_idx_t'(FIELD_OFFSET);
  localparam byte_idx_t HI_IDX = byte_idx_t'(FIELD_OFFSET + NBYTES);

  logic [$bits(field_t)-1:0] field_q;
  logic                      hit;
  byte_idx_t                 rel;
  byte_idx_t                 lane;

  assign hit  = byte_valid_i && (byte_idx_i >= LO_IDX) && (byte_idx_i < HI_IDX);
  assign rel  = byte_idx_i - LO_IDX;
  assign lane = MSB_FIRST ? byte_idx_t'(NBYTES - 1) - rel : rel;

  // each new block overwrites every lane of the field
  always_ff @(posedge clk) begin
    if (rst) begin
      field_q <= '0;
    end else if (hit) begin
      for (int l = 0; l < NBYTES; l++) begin
        if (lane == byte_idx_t'(l))
          field_q[l*8 +: 8] <= byte_data_i;
      end
    end
  end

  assign field_o = field_t'(field_q);

endmodule

//--- rtl/sd_block_reader.sv
// SD block reader.
// Reads one block from the SPI host over its busy handshake and
// streams the bytes with their index. Started and finished by a
// four-phase req/ack exchange with the sequencer.

`timescale 1ns/100ps

module sd_block_reader (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      read_req_i,
  output logic                      read_ack_o,
  input  logic                      spi_busy_i,
  input  autotest_sd_pkg::sd_byte_t spi_data_out_i,
  output logic                      spi_r_block_o,
  output logic                      spi_r_byte_o,
  output logic                      byte_valid_o,
  output autotest_sd_pkg::byte_idx_t byte_idx_o,
  output autotest_sd_pkg::sd_byte_t byte_data_o
);

  import autotest_sd_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_BLOCK,
    S_BLOCK_WAIT,
    S_BYTE,
    S_BYTE_WAIT,
    S_ACK
  } state_t;

  localparam byte_idx_t LAST_IDX = byte_idx_t'(BLOCK_BYTES - 1);

  state_t    state_q;
  state_t    state_d;
  byte_idx_t cnt_q;
  logic      last_byte;

  // host data is valid in the cycle busy falls
  assign byte_valid_o = (state_q == S_BYTE_WAIT) && !spi_busy_i;
  assign byte_idx_o   = cnt_q;
  assign byte_data_o  = spi_data_out_i;
  assign last_byte    = (cnt_q == LAST_IDX);

  assign spi_r_block_o = (state_q == S_BLOCK) || (state_q == S_BLOCK_WAIT) ||
                         (state_q == S_BYTE) || (state_q == S_BYTE_WAIT);
  assign spi_r_byte_o  = (state_q == S_BYTE);
  assign read_ack_o    = (state_q == S_ACK);

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:
        if (read_req_i)
          state_d = S_BLOCK;
      S_BLOCK:
        if (spi_busy_i)
          state_d = S_BLOCK_WAIT;
      S_BLOCK_WAIT:
        if (!spi_busy_i)
          state_d = S_BYTE;
      S_BYTE:
        if (spi_busy_i)
          state_d = S_BYTE_WAIT;
      S_BYTE_WAIT:
        if (!spi_busy_i)
          state_d = last_byte ? S_ACK : S_BYTE;
      // hold ack until the sequencer lets go of req
      S_ACK:
        if (!read_req_i)
          state_d = S_IDLE;
      default:
        state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == S_IDLE)
        cnt_q <= '0;
      else if (byte_valid_o)
        cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

//--- rtl/autotest_sd_pkg.sv
// SD card and test record layout for the self-test harness.
// One record per 512-byte block: signature, operand A, operand B
// and the expected result, packed back to back from byte 0.

package autotest_sd_pkg;

  localparam int BLOCK_BYTES = 512;

  typedef logic [9:0]  byte_idx_t;
  typedef logic [7:0]  sd_byte_t;
  typedef logic [31:0] block_addr_t;
  typedef logic [31:0] sig_t;
  typedef logic [31:0] err_count_t;

  // first record block on the card
  localparam block_addr_t START_BLOCK = 32'h0010_0000;

  // record mark with the first card byte most significant
  localparam sig_t SIGNATURE = 32'hAABB_CCDD;

  // byte offsets inside a block
  localparam int SIG_OFFSET = 0;
  localparam int A_OFFSET   = 4;
  localparam int B_OFFSET   = A_OFFSET + autotest_uut_pkg::IN_A_BYTES;
  localparam int EXP_OFFSET = B_OFFSET + autotest_uut_pkg::IN_B_BYTES;

endpackage

//--- rtl/autotest_uut_pkg.sv
// Operand and result formats of the unit under test.
// Field sizes are whole bytes, since they are loaded from the card.

package autotest_uut_pkg;

  localparam int IN_A_BYTES = 4;
  localparam int IN_B_BYTES = 4;
  localparam int RES_BYTES  = 4;

  typedef logic [IN_A_BYTES*8-1:0] in_a_t;
  typedef logic [IN_B_BYTES*8-1:0] in_b_t;
  typedef logic [RES_BYTES*8-1:0]  result_t;

endpackage
